// ==== design/cpu_pkg.sv ====
package cpu_pkg;

	localparam int word_w  = 16;
	localparam int reg_aw  = 3;
	localparam int imem_aw = 8;
	localparam int dmem_aw = 6;

	// Major opcode in inst[15:11]
	typedef enum logic [4:0] {
		op_nop   = 5'b00001,
		op_b     = 5'b00010,
		op_beqz  = 5'b00100,
		op_addiu = 5'b01001,
		op_li    = 5'b01101,
		op_lw    = 5'b10011,
		op_sw    = 5'b11011,
		op_rrr   = 5'b11100,
		op_rr    = 5'b11101,
		op_halt  = 5'b11111
	} opcode_e;

	// Function codes, inst[1:0] for RRR and inst[4:0] for RR
	localparam logic [1:0] fn_addu = 2'b01;
	localparam logic [1:0] fn_subu = 2'b11;
	localparam logic [4:0] fn_and  = 5'b01100;
	localparam logic [4:0] fn_or   = 5'b01101;
	localparam logic [4:0] fn_slt  = 5'b00010;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [1:0] {
		seq_idle,
		seq_issue,
		seq_wait,
		seq_halted
	} seq_state_e;

	typedef struct packed {
		logic              valid;
		logic [word_w-1:0] pc;
		logic [word_w-1:0] inst;
	} fetch_t;

	typedef struct packed {
		logic              valid;
		logic [word_w-1:0] pc;
		alu_op_e           alu_op;
		logic [word_w-1:0] op_a;
		logic [word_w-1:0] op_b;
		logic [word_w-1:0] store_data;
		logic              reg_we;
		logic [reg_aw-1:0] reg_addr;
		logic              mem_rd;
		logic              mem_we;
		logic              is_branch;
		logic              is_beqz;
		logic [word_w-1:0] br_off;
		logic              is_halt;
	} decode_t;

	typedef struct packed {
		logic              valid;
		logic [word_w-1:0] pc;
		logic [word_w-1:0] result;
		logic [word_w-1:0] store_data;
		logic              reg_we;
		logic [reg_aw-1:0] reg_addr;
		logic              mem_rd;
		logic              mem_we;
		logic              is_halt;
	} exec_t;

	// Fields not used by an instruction retire as zero
	typedef struct packed {
		logic               [word_w-1:0] pc;
		logic                            reg_we;
		logic               [reg_aw-1:0] reg_addr;
		logic               [word_w-1:0] reg_data;
		logic                            mem_we;
		logic              [dmem_aw-1:0] mem_addr;
		logic               [word_w-1:0] mem_data;
	} retire_t;

	typedef struct packed {
		logic              taken;
		logic [word_w-1:0] target;
	} redirect_t;

endpackage

// ==== design/exec_unit.sv ====
module exec_unit (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::decode_t   dec,
	output cpu_pkg::exec_t     exe,
	output cpu_pkg::redirect_t redirect
);

	logic [cpu_pkg::word_w-1:0] result;
	logic [cpu_pkg::word_w-1:0] target;
	logic taken;

	always_comb begin
		unique case (dec.alu_op)
			cpu_pkg::alu_add: result = dec.op_a + dec.op_b;
			cpu_pkg::alu_sub: result = dec.op_a - dec.op_b;
			cpu_pkg::alu_and: result = dec.op_a & dec.op_b;
			cpu_pkg::alu_or: result = dec.op_a | dec.op_b;
			cpu_pkg::alu_slt: begin
				if ($signed(dec.op_a) < $signed(dec.op_b)) begin
					result = cpu_pkg::word_w'(1);
				end else begin
					result = '0;
				end
			end
			default: result = dec.op_b;
		endcase
	end

	// B always, BEQZ only on a zero register
	assign taken = dec.is_branch && (!dec.is_beqz || dec.op_a == '0);
	assign target = dec.pc + cpu_pkg::word_w'(1) + dec.br_off;

	always_ff @(posedge clk) begin
		if (rst) begin
			exe <= '0;
			redirect <= '0;
		end else if (dec.valid) begin
			exe.valid <= 1'b1;
			exe.pc <= dec.pc;
			exe.result <= result;
			exe.store_data <= dec.store_data;
			exe.reg_we <= dec.reg_we;
			exe.reg_addr <= dec.reg_addr;
			exe.mem_rd <= dec.mem_rd;
			exe.mem_we <= dec.mem_we;
			exe.is_halt <= dec.is_halt;
			redirect.taken <= taken;
			redirect.target <= target;
		end else begin
			exe.valid <= 1'b0;
		end
	end

endmodule

// ==== design/fetch_unit.sv ====
module fetch_unit (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        run,
	input  logic                        boot_we,
	input  logic [cpu_pkg::imem_aw-1:0] boot_addr,
	input  logic [cpu_pkg::word_w-1:0]  boot_data,
	input  cpu_pkg::redirect_t          redirect,
	input  logic                        retire_done,
	input  logic                        halt_seen,
	output cpu_pkg::fetch_t             fetch,
	output logic                        halted
);

	cpu_pkg::seq_state_e state;
	cpu_pkg::seq_state_e state_nx;
	logic [cpu_pkg::word_w-1:0] pc;
	logic [cpu_pkg::word_w-1:0] fetch_addr;
	logic [cpu_pkg::word_w-1:0] imem [2**cpu_pkg::imem_aw];
	logic issue;

	// A taken branch overrides the sequential pc
	assign fetch_addr = redirect.taken ? redirect.target : pc;

	always_comb begin
		state_nx = state;
		issue = 1'b0;
		unique case (state)
			cpu_pkg::seq_idle: begin
				if (run) begin
					issue = 1'b1;
					state_nx = cpu_pkg::seq_issue;
				end
			end
			cpu_pkg::seq_issue: begin
				state_nx = cpu_pkg::seq_wait;
			end
			cpu_pkg::seq_wait: begin
				if (retire_done) begin
					if (halt_seen) begin
						state_nx = cpu_pkg::seq_halted;
					end else begin
						issue = 1'b1;
						state_nx = cpu_pkg::seq_issue;
					end
				end
			end
			cpu_pkg::seq_halted: begin
				state_nx = cpu_pkg::seq_halted;
			end
			default: begin
				state_nx = cpu_pkg::seq_idle;
			end
		endcase
	end

	// Boot port, open only before the core starts
	always_ff @(posedge clk) begin
		if (boot_we && state == cpu_pkg::seq_idle) begin
			imem[boot_addr] <= boot_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cpu_pkg::seq_idle;
			pc <= '0;
			fetch <= '0;
		end else begin
			state <= state_nx;
			if (issue) begin
				pc <= fetch_addr + cpu_pkg::word_w'(1);
				fetch.valid <= 1'b1;
				fetch.pc <= fetch_addr;
				fetch.inst <= imem[fetch_addr[cpu_pkg::imem_aw-1:0]];
			end else begin
				fetch.valid <= 1'b0;
			end
		end
	end

	assign halted = (state == cpu_pkg::seq_halted);

endmodule

// ==== design/inst_decoder.sv ====
module inst_decoder (
	input  logic                       clk,
	input  logic                       rst,
	input  cpu_pkg::fetch_t            fetch,
	output logic [cpu_pkg::reg_aw-1:0] rd_addr_a,
	output logic [cpu_pkg::reg_aw-1:0] rd_addr_b,
	input  logic [cpu_pkg::word_w-1:0] rd_data_a,
	input  logic [cpu_pkg::word_w-1:0] rd_data_b,
	output cpu_pkg::decode_t           dec,
	output logic                       bad_opcode
);

	cpu_pkg::opcode_e op;
	cpu_pkg::decode_t dec_nx;
	logic [cpu_pkg::reg_aw-1:0] rx;
	logic [cpu_pkg::reg_aw-1:0] ry;
	logic [cpu_pkg::reg_aw-1:0] rz;
	logic [cpu_pkg::word_w-1:0] imm8_s;
	logic [cpu_pkg::word_w-1:0] imm8_z;
	logic [cpu_pkg::word_w-1:0] imm5_s;
	logic [cpu_pkg::word_w-1:0] imm11_s;
	logic unknown;

	assign op = cpu_pkg::opcode_e'(fetch.inst[15:11]);
	assign rx = fetch.inst[10:8];
	assign ry = fetch.inst[7:5];
	assign rz = fetch.inst[4:2];

	assign imm8_s = {{(cpu_pkg::word_w-8){fetch.inst[7]}}, fetch.inst[7:0]};
	assign imm8_z = {{(cpu_pkg::word_w-8){1'b0}}, fetch.inst[7:0]};
	assign imm5_s = {{(cpu_pkg::word_w-5){fetch.inst[4]}}, fetch.inst[4:0]};
	assign imm11_s = {{(cpu_pkg::word_w-11){fetch.inst[10]}}, fetch.inst[10:0]};

	// Port a always reads rx, port b reads ry
	assign rd_addr_a = rx;
	assign rd_addr_b = ry;

	always_comb begin
		dec_nx = '0;
		dec_nx.valid = 1'b1;
		dec_nx.pc = fetch.pc;
		dec_nx.alu_op = cpu_pkg::alu_pass_b;
		unknown = 1'b0;
		case (op)
			cpu_pkg::op_nop: begin
			end
			cpu_pkg::op_b: begin
				dec_nx.is_branch = 1'b1;
				dec_nx.br_off = imm11_s;
			end
			cpu_pkg::op_beqz: begin
				dec_nx.is_branch = 1'b1;
				dec_nx.is_beqz = 1'b1;
				dec_nx.op_a = rd_data_a;
				dec_nx.br_off = imm8_s;
			end
			cpu_pkg::op_addiu: begin
				dec_nx.alu_op = cpu_pkg::alu_add;
				dec_nx.op_a = rd_data_a;
				dec_nx.op_b = imm8_s;
				dec_nx.reg_we = 1'b1;
				dec_nx.reg_addr = rx;
			end
			cpu_pkg::op_li: begin
				dec_nx.op_b = imm8_z;
				dec_nx.reg_we = 1'b1;
				dec_nx.reg_addr = rx;
			end
			cpu_pkg::op_lw: begin
				dec_nx.alu_op = cpu_pkg::alu_add;
				dec_nx.op_a = rd_data_a;
				dec_nx.op_b = imm5_s;
				dec_nx.mem_rd = 1'b1;
				dec_nx.reg_we = 1'b1;
				dec_nx.reg_addr = ry;
			end
			cpu_pkg::op_sw: begin
				dec_nx.alu_op = cpu_pkg::alu_add;
				dec_nx.op_a = rd_data_a;
				dec_nx.op_b = imm5_s;
				dec_nx.store_data = rd_data_b;
				dec_nx.mem_we = 1'b1;
			end
			cpu_pkg::op_rrr: begin
				dec_nx.op_a = rd_data_a;
				dec_nx.op_b = rd_data_b;
				dec_nx.reg_addr = rz;
				if (fetch.inst[1:0] == cpu_pkg::fn_addu) begin
					dec_nx.alu_op = cpu_pkg::alu_add;
					dec_nx.reg_we = 1'b1;
				end else if (fetch.inst[1:0] == cpu_pkg::fn_subu) begin
					dec_nx.alu_op = cpu_pkg::alu_sub;
					dec_nx.reg_we = 1'b1;
				end else begin
					unknown = 1'b1;
				end
			end
			cpu_pkg::op_rr: begin
				// Result goes back to rx, SLT included
				dec_nx.op_a = rd_data_a;
				dec_nx.op_b = rd_data_b;
				dec_nx.reg_addr = rx;
				dec_nx.reg_we = 1'b1;
				if (fetch.inst[4:0] == cpu_pkg::fn_and) begin
					dec_nx.alu_op = cpu_pkg::alu_and;
				end else if (fetch.inst[4:0] == cpu_pkg::fn_or) begin
					dec_nx.alu_op = cpu_pkg::alu_or;
				end else if (fetch.inst[4:0] == cpu_pkg::fn_slt) begin
					dec_nx.alu_op = cpu_pkg::alu_slt;
				end else begin
					unknown = 1'b1;
				end
			end
			cpu_pkg::op_halt: begin
				dec_nx.is_halt = 1'b1;
			end
			default: begin
				unknown = 1'b1;
			end
		endcase
		// Unknown encodings stop the core like a halt
		if (unknown) begin
			dec_nx = '0;
			dec_nx.valid = 1'b1;
			dec_nx.pc = fetch.pc;
			dec_nx.alu_op = cpu_pkg::alu_pass_b;
			dec_nx.is_halt = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec <= '0;
			bad_opcode <= 1'b0;
		end else begin
			if (fetch.valid) begin
				dec <= dec_nx;
			end else begin
				dec.valid <= 1'b0;
			end
			if (fetch.valid && unknown) begin
				bad_opcode <= 1'b1;
			end
		end
	end

endmodule

// ==== design/reg_file.sv ====
module reg_file (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [cpu_pkg::reg_aw-1:0] rd_addr_a,
	input  logic [cpu_pkg::reg_aw-1:0] rd_addr_b,
	output logic [cpu_pkg::word_w-1:0] rd_data_a,
	output logic [cpu_pkg::word_w-1:0] rd_data_b,
	input  logic                       we,
	input  logic [cpu_pkg::reg_aw-1:0] wr_addr,
	input  logic [cpu_pkg::word_w-1:0] wr_data
);

	logic [cpu_pkg::word_w-1:0] regs [2**cpu_pkg::reg_aw];

	// r0 is an ordinary register here
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**cpu_pkg::reg_aw; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

// ==== design/result_stage.sv ====
module result_stage (
	input  logic                       clk,
	input  logic                       rst,
	input  cpu_pkg::exec_t             exe,
	output logic                       reg_we,
	output logic [cpu_pkg::reg_aw-1:0] reg_addr,
	output logic [cpu_pkg::word_w-1:0] reg_data,
	output logic                       retire_valid,
	output cpu_pkg::retire_t           retire,
	output logic                       halt_seen
);

	logic [cpu_pkg::word_w-1:0] dmem [2**cpu_pkg::dmem_aw];
	logic [cpu_pkg::dmem_aw-1:0] mem_addr;
	logic [cpu_pkg::word_w-1:0] load_data;
	cpu_pkg::exec_t mem_q;

	assign mem_addr = exe.result[cpu_pkg::dmem_aw-1:0];
	assign load_data = dmem[mem_addr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**cpu_pkg::dmem_aw; i++) begin
				dmem[i] <= '0;
			end
		end else if (exe.valid && exe.mem_we) begin
			dmem[mem_addr] <= exe.store_data;
		end
	end

	// Access cycle, load data replaces the address
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_q <= '0;
		end else if (exe.valid) begin
			mem_q <= exe;
			if (exe.mem_rd) begin
				mem_q.result <= load_data;
			end
		end else begin
			mem_q.valid <= 1'b0;
		end
	end

	assign reg_we = mem_q.valid && mem_q.reg_we;
	assign reg_addr = mem_q.reg_addr;
	assign reg_data = mem_q.result;

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			retire_valid <= mem_q.valid;
			halt_seen <= mem_q.valid && mem_q.is_halt;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_q.valid) begin
			retire.pc <= mem_q.pc;
			retire.reg_we <= mem_q.reg_we;
			retire.reg_addr <= mem_q.reg_we ? mem_q.reg_addr : '0;
			retire.reg_data <= mem_q.reg_we ? mem_q.result : '0;
			retire.mem_we <= mem_q.mem_we;
			retire.mem_addr <= mem_q.mem_we ? mem_q.result[cpu_pkg::dmem_aw-1:0] : '0;
			retire.mem_data <= mem_q.mem_we ? mem_q.store_data : '0;
		end
	end

endmodule

// ==== design/zhx_core.sv ====
module zhx_core (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        boot_we,
	input  logic [cpu_pkg::imem_aw-1:0] boot_addr,
	input  logic [cpu_pkg::word_w-1:0]  boot_data,
	input  logic                        run,
	output logic                        retire_valid,
	output cpu_pkg::retire_t            retire,
	output logic                        halted,
	output logic                        bad_opcode
);

	cpu_pkg::fetch_t fetch;
	cpu_pkg::decode_t dec;
	cpu_pkg::exec_t exe;
	cpu_pkg::redirect_t redirect;
	logic [cpu_pkg::reg_aw-1:0] rd_addr_a;
	logic [cpu_pkg::reg_aw-1:0] rd_addr_b;
	logic [cpu_pkg::word_w-1:0] rd_data_a;
	logic [cpu_pkg::word_w-1:0] rd_data_b;
	logic wb_we;
	logic [cpu_pkg::reg_aw-1:0] wb_addr;
	logic [cpu_pkg::word_w-1:0] wb_data;
	logic halt_seen;

	fetch_unit fetch_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.boot_we(boot_we),
		.boot_addr(boot_addr),
		.boot_data(boot_data),
		.redirect(redirect),
		.retire_done(retire_valid),
		.halt_seen(halt_seen),
		.fetch(fetch),
		.halted(halted)
	);

	inst_decoder decode_i (
		.clk(clk),
		.rst(rst),
		.fetch(fetch),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.dec(dec),
		.bad_opcode(bad_opcode)
	);

	reg_file regs_i (
		.clk(clk),
		.rst(rst),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.we(wb_we),
		.wr_addr(wb_addr),
		.wr_data(wb_data)
	);

	exec_unit exec_i (
		.clk(clk),
		.rst(rst),
		.dec(dec),
		.exe(exe),
		.redirect(redirect)
	);

	result_stage result_i (
		.clk(clk),
		.rst(rst),
		.exe(exe),
		.reg_we(wb_we),
		.reg_addr(wb_addr),
		.reg_data(wb_data),
		.retire_valid(retire_valid),
		.retire(retire),
		.halt_seen(halt_seen)
	);

endmodule

// ==== test/core_sva.sv ====
module core_sva (
	input logic clk,
	input logic rst,
	input logic retire_valid,
	input logic halt_seen,
	input logic fetch_valid,
	input logic halted
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// One token in flight, so retire pulses are always apart
	single_retire: assert property (@(posedge clk) disable iff (rst)
		retire_valid |=> !retire_valid)
	else begin
		fail_count++;
		$error("retire_valid high on two consecutive cycles");
	end

	no_fetch_halted: assert property (@(posedge clk) disable iff (rst)
		halted |-> !fetch_valid)
	else begin
		fail_count++;
		$error("fetch issued while halted");
	end

	// Next issue comes on the edge after a non-halt retirement
	fetch_after_retire: assert property (@(posedge clk) disable iff (rst)
		retire_valid && !halt_seen |=> fetch_valid)
	else begin
		fail_count++;
		$error("fetch did not follow retire_valid by one cycle");
	end

endmodule

bind fetch_unit core_sva sva_i (
	.clk(clk),
	.rst(rst),
	.retire_valid(retire_done),
	.halt_seen(halt_seen),
	.fetch_valid(fetch.valid),
	.halted(halted)
);

// ==== test/core_tb.sv ====
module core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [cpu_pkg::imem_aw-1:0] addr;
		logic [cpu_pkg::word_w-1:0]  word;
		logic                        retires;
		cpu_pkg::retire_t            exp;
	} prog_row_t;

	logic clk;
	logic rst;
	logic boot_we;
	logic [cpu_pkg::imem_aw-1:0] boot_addr;
	logic [cpu_pkg::word_w-1:0] boot_data;
	logic run;
	logic retire_valid;
	cpu_pkg::retire_t retire;
	logic halted;
	logic bad_opcode;

	prog_row_t prog [$];
	int seed;

	zhx_core dut_i (
		.clk(clk),
		.rst(rst),
		.boot_we(boot_we),
		.boot_addr(boot_addr),
		.boot_data(boot_data),
		.run(run),
		.retire_valid(retire_valid),
		.retire(retire),
		.halted(halted),
		.bad_opcode(bad_opcode)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [15:0] enc_imm8(cpu_pkg::opcode_e op, logic [2:0] rx,
		logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic logic [15:0] enc_mem(cpu_pkg::opcode_e op, logic [2:0] rx,
		logic [2:0] ry, logic [4:0] off);
		return {op, rx, ry, off};
	endfunction

	function automatic logic [15:0] enc_rrr(logic [2:0] rx, logic [2:0] ry, logic [2:0] rz,
		logic [1:0] fn);
		return {cpu_pkg::op_rrr, rx, ry, rz, fn};
	endfunction

	function automatic logic [15:0] enc_rr(logic [2:0] rx, logic [2:0] ry, logic [4:0] fn);
		return {cpu_pkg::op_rr, rx, ry, fn};
	endfunction

	function automatic cpu_pkg::retire_t ret_reg(logic [15:0] pc, logic [2:0] ra,
		logic [15:0] data);
		cpu_pkg::retire_t r;
		r = '0;
		r.pc = pc;
		r.reg_we = 1'b1;
		r.reg_addr = ra;
		r.reg_data = data;
		return r;
	endfunction

	function automatic cpu_pkg::retire_t ret_store(logic [15:0] pc, logic [5:0] ma,
		logic [15:0] data);
		cpu_pkg::retire_t r;
		r = '0;
		r.pc = pc;
		r.mem_we = 1'b1;
		r.mem_addr = ma;
		r.mem_data = data;
		return r;
	endfunction

	// Branches, NOP and halt write nothing
	function automatic cpu_pkg::retire_t ret_none(logic [15:0] pc);
		cpu_pkg::retire_t r;
		r = '0;
		r.pc = pc;
		return r;
	endfunction

	task automatic add_row(input logic [15:0] word, input logic retires,
		input cpu_pkg::retire_t exp);
		prog_row_t row;
		row.addr = cpu_pkg::imem_aw'(prog.size());
		row.word = word;
		row.retires = retires;
		row.exp = exp;
		prog.push_back(row);
	endtask

	task automatic build_main_program();
		logic [15:0] r [8];
		logic [15:0] sum;
		logic [7:0] k1;
		logic [7:0] k2;
		logic [7:0] k3;
		logic [7:0] k5;
		prog.delete();
		foreach (r[i]) r[i] = '0;
		k1 = $random(seed);
		k1[7] = 1'b1;
		k2 = $random(seed);
		k2[7] = 1'b1;
		k3 = $random(seed);
		k5 = $random(seed);
		r[1] = {8'h00, k1};
		add_row(enc_imm8(cpu_pkg::op_li, 3'd1, k1), 1'b1, ret_reg(0, 3'd1, r[1]));
		r[2] = {8'h00, k3};
		add_row(enc_imm8(cpu_pkg::op_li, 3'd2, k3), 1'b1, ret_reg(1, 3'd2, r[2]));
		// Negative immediate into r0
		r[0] = r[0] + {{8{k2[7]}}, k2};
		add_row(enc_imm8(cpu_pkg::op_addiu, 3'd0, k2), 1'b1, ret_reg(2, 3'd0, r[0]));
		r[4] = r[1] + r[2];
		add_row(enc_rrr(3'd1, 3'd2, 3'd4, cpu_pkg::fn_addu), 1'b1, ret_reg(3, 3'd4, r[4]));
		r[5] = r[1] - r[2];
		add_row(enc_rrr(3'd1, 3'd2, 3'd5, cpu_pkg::fn_subu), 1'b1, ret_reg(4, 3'd5, r[5]));
		r[4] = r[4] & r[2];
		add_row(enc_rr(3'd4, 3'd2, cpu_pkg::fn_and), 1'b1, ret_reg(5, 3'd4, r[4]));
		r[5] = r[5] | r[1];
		add_row(enc_rr(3'd5, 3'd1, cpu_pkg::fn_or), 1'b1, ret_reg(6, 3'd5, r[5]));
		r[0] = ($signed(r[0]) < $signed(r[1])) ? 16'd1 : 16'd0;
		add_row(enc_rr(3'd0, 3'd1, cpu_pkg::fn_slt), 1'b1, ret_reg(7, 3'd0, r[0]));
		// Leaves r1 at zero for the taken BEQZ
		r[1] = ($signed(r[1]) < $signed(r[0])) ? 16'd1 : 16'd0;
		add_row(enc_rr(3'd1, 3'd0, cpu_pkg::fn_slt), 1'b1, ret_reg(8, 3'd1, r[1]));
		r[7] = {8'h00, k5};
		add_row(enc_imm8(cpu_pkg::op_li, 3'd7, k5), 1'b1, ret_reg(9, 3'd7, r[7]));
		sum = r[7] + 16'd3;
		add_row(enc_mem(cpu_pkg::op_sw, 3'd7, 3'd5, 5'd3), 1'b1,
			ret_store(10, sum[cpu_pkg::dmem_aw-1:0], r[5]));
		r[7] = r[7] + 16'd4;
		add_row(enc_imm8(cpu_pkg::op_addiu, 3'd7, 8'd4), 1'b1, ret_reg(11, 3'd7, r[7]));
		// Offset -1 lands on the stored word
		r[6] = r[5];
		add_row(enc_mem(cpu_pkg::op_lw, 3'd7, 3'd6, 5'h1f), 1'b1, ret_reg(12, 3'd6, r[6]));
		add_row(enc_imm8(cpu_pkg::op_beqz, 3'd1, 8'd1), 1'b1, ret_none(13));
		add_row(enc_imm8(cpu_pkg::op_li, 3'd3, 8'h55), 1'b0, ret_none(14));
		// r6 holds r5, which keeps the high bit of old r1
		add_row(enc_imm8(cpu_pkg::op_beqz, 3'd6, 8'd1), 1'b1, ret_none(15));
		add_row({cpu_pkg::op_b, 11'd2}, 1'b1, ret_none(16));
		add_row(enc_imm8(cpu_pkg::op_li, 3'd3, 8'haa), 1'b0, ret_none(17));
		add_row({cpu_pkg::op_halt, 11'd0}, 1'b0, ret_none(18));
		add_row({cpu_pkg::op_nop, 11'd0}, 1'b1, ret_none(19));
		add_row({cpu_pkg::op_halt, 11'd0}, 1'b1, ret_none(20));
	endtask

	task automatic build_bad_program();
		logic [7:0] k;
		prog.delete();
		k = $random(seed);
		add_row(enc_imm8(cpu_pkg::op_li, 3'd2, k), 1'b1, ret_reg(0, 3'd2, {8'h00, k}));
		// Opcode 00000 is not decoded
		add_row(16'h0000, 1'b1, ret_none(1));
		add_row(enc_imm8(cpu_pkg::op_li, 3'd3, 8'd1), 1'b0, ret_none(2));
	endtask

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_retire(input int row, input cpu_pkg::retire_t got,
		input cpu_pkg::retire_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("MISMATCH retire row %0d: got %h expected %h", row, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_stop($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		run <= 1'b0;
		boot_we <= 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("retire_valid", retire_valid, 1'b0);
		check_flag("halted", halted, 1'b0);
		check_flag("bad_opcode", bad_opcode, 1'b0);
	endtask

	task automatic wait_retire(input int row);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < 20 && !seen; n++) begin
			@(negedge clk);
			seen = retire_valid;
		end
		if (!seen) begin
			fail_stop($sformatf("Timeout: row %0d did not retire within 20 cycles", row));
		end
	endtask

	task automatic wait_halted();
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < 20 && !seen; n++) begin
			@(negedge clk);
			seen = halted;
		end
		if (!seen) begin
			fail_stop("Timeout: core did not halt within 20 cycles");
		end
	endtask

	task automatic check_quiet();
		for (int n = 0; n < 20; n++) begin
			@(negedge clk);
			if (retire_valid) begin
				fail_stop("Unexpected retirement after halt");
			end
		end
	endtask

	task automatic load_program();
		foreach (prog[i]) begin
			@(posedge clk);
			boot_we <= 1'b1;
			boot_addr <= prog[i].addr;
			boot_data <= prog[i].word;
		end
		@(posedge clk);
		boot_we <= 1'b0;
		run <= 1'b1;
	endtask

	task automatic check_program();
		foreach (prog[i]) begin
			if (prog[i].retires) begin
				wait_retire(i);
				check_retire(i, retire, prog[i].exp);
			end
		end
	endtask

	initial begin
		seed = 51;
		rst = 1'b1;
		run = 1'b0;
		boot_we = 1'b0;
		boot_addr = '0;
		boot_data = '0;
		apply_reset();

		build_main_program();
		load_program();
		check_program();
		wait_halted();
		check_flag("bad_opcode", bad_opcode, 1'b0);
		check_quiet();
		// Halted holds while the core stays quiet
		check_flag("halted", halted, 1'b1);

		// Second run stops on an undecodable word
		apply_reset();
		build_bad_program();
		load_program();
		check_program();
		wait_halted();
		check_flag("bad_opcode", bad_opcode, 1'b1);
		check_quiet();
		check_flag("halted", halted, 1'b1);

		if (dut_i.fetch_i.sva_i.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// ==== zhx_core.f ====
design/cpu_pkg.sv
design/fetch_unit.sv
design/inst_decoder.sv
design/reg_file.sv
design/exec_unit.sv
design/result_stage.sv
design/zhx_core.sv
test/core_sva.sv
test/core_tb.sv
